// File: hw/pid_controller.sv
module pid_controller (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       sample_valid,
    input  pid_fixed_pkg::pid_sample_t sample,
    input  pid_fixed_pkg::pid_coeff_t  coeff,
    input  pid_fixed_pkg::fix_t        ysat,
    output pid_fixed_pkg::fix_t        y_out,
    output logic                       busy,
    output logic                       out_valid
);
    import pid_fixed_pkg::*;
    import pid_ctrl_pkg::*;

    logic        take;
    logic        commit;
    pid_hist_t   hist;
    mac_op_t     mac_op;
    pid_result_t result;

    // commit closes the sample for everyone
    assign out_valid = commit;

    pid_term_sequencer pid_term_sequencer_i (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .coeff        (coeff),
        .hist         (hist),
        .done         (commit),
        .take         (take),
        .busy         (busy),
        .mac_op       (mac_op)
    );

    pid_history pid_history_i (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .take   (take),
        .sample (sample),
        .commit (commit),
        .result (result),
        .hist   (hist)
    );

    pid_mac_datapath pid_mac_datapath_i (
        .aclk   (aclk),
        .rst_n  (rst_n),
        .mac_op (mac_op),
        .ysat   (ysat),
        .hist   (hist),
        .result (result),
        .commit (commit),
        .y_out  (y_out)
    );

endmodule

// File: hw/pid_ctrl_pkg.sv
package pid_ctrl_pkg;

    // ========================================
    // sequencing
    // ========================================
    localparam int TERM_COUNT = 8;
    localparam int TERM_IDX_W = $clog2(TERM_COUNT);

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_DRAIN
    } seq_state_e;

    // ========================================
    // MAC interface
    // ========================================
    typedef enum logic [1:0] {
        OP_LOAD,  // accumulator takes the product
        OP_ACC,   // accumulator adds the product
        OP_LAST   // add, then close the sample
    } mac_opcode_e;

    typedef struct packed {
        logic               valid;
        mac_opcode_e        opcode;
        pid_fixed_pkg::fix_t coef;
        pid_fixed_pkg::fix_t operand;
    } mac_op_t;

endpackage

// File: hw/pid_fixed_pkg.sv
package pid_fixed_pkg;

    // ========================================
    // number format
    // ========================================
    localparam int FIX_WIDTH  = 32;
    localparam int FRAC_BITS  = 16;
    localparam int PROD_WIDTH = 2 * FIX_WIDTH;

    // signed Q16.16, two's-complement wrap
    typedef logic signed [FIX_WIDTH-1:0] fix_t;

    // ========================================
    // controller data
    // ========================================
    typedef struct packed {
        fix_t a0;
        fix_t c1;
        fix_t c2;
        fix_t c3;
        fix_t c4;
        fix_t c5;
        fix_t c6;
        fix_t c7;
    } pid_coeff_t;

    // target and measured speed
    typedef struct packed {
        fix_t w;
        fix_t x;
    } pid_sample_t;

    // y_d1 and ysat_d1 are read-only views for the output adder
    typedef struct packed {
        pid_sample_t cur;
        fix_t        w_d1;
        fix_t        w_d2;
        fix_t        x_d1;
        fix_t        x_d2;
        fix_t        dy_d1;
        fix_t        aw_err;
        fix_t        y_d1;
        fix_t        ysat_d1;
    } pid_hist_t;

    typedef struct packed {
        fix_t delta_y;
        fix_t y_unsat;
        fix_t y_sat;
    } pid_result_t;

endpackage

// File: hw/pid_history.sv
module pid_history (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       take,
    input  pid_fixed_pkg::pid_sample_t sample,
    input  logic                       commit,
    input  pid_fixed_pkg::pid_result_t result,
    output pid_fixed_pkg::pid_hist_t   hist
);
    import pid_fixed_pkg::*;

    pid_sample_t cur;
    fix_t        w_d1;
    fix_t        w_d2;
    fix_t        x_d1;
    fix_t        x_d2;
    fix_t        dy_d1;
    fix_t        y_d1;
    fix_t        ysat_d1;
    fix_t        aw_err;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            cur     <= '0;
            w_d1    <= '0;
            w_d2    <= '0;
            x_d1    <= '0;
            x_d2    <= '0;
            dy_d1   <= '0;
            y_d1    <= '0;
            ysat_d1 <= '0;
        end else begin
            if (take) begin
                cur <= sample;
            end
            // shift once per finished sample
            if (commit) begin
                w_d2    <= w_d1;
                w_d1    <= cur.w;
                x_d2    <= x_d1;
                x_d1    <= cur.x;
                dy_d1   <= result.delta_y;
                y_d1    <= result.y_unsat;
                ysat_d1 <= result.y_sat;
            end
        end
    end

    // back-calculation error, one tap
    assign aw_err = ysat_d1 - y_d1;

    assign hist = '{
        cur:     cur,
        w_d1:    w_d1,
        w_d2:    w_d2,
        x_d1:    x_d1,
        x_d2:    x_d2,
        dy_d1:   dy_d1,
        aw_err:  aw_err,
        y_d1:    y_d1,
        ysat_d1: ysat_d1
    };

endmodule

// File: hw/pid_mac_datapath.sv
module pid_mac_datapath (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  pid_ctrl_pkg::mac_op_t      mac_op,
    input  pid_fixed_pkg::fix_t        ysat,
    input  pid_fixed_pkg::pid_hist_t   hist,
    output pid_fixed_pkg::pid_result_t result,
    output logic                       commit,
    output pid_fixed_pkg::fix_t        y_out
);
    import pid_fixed_pkg::*;
    import pid_ctrl_pkg::*;

    logic signed [PROD_WIDTH-1:0] prod_full;

    // stage 1
    logic                         prod_valid;
    mac_opcode_e                  prod_op;
    fix_t                         prod_q;

    // stage 2
    fix_t                         acc;
    logic                         acc_last;

    // output stage
    fix_t                         y_sum;
    fix_t                         ysat_neg;
    fix_t                         y_clamped;

    // ========================================
    // stage 1, Q16.16 multiply
    // ========================================
    assign prod_full = $signed(mac_op.coef) * $signed(mac_op.operand);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
        end else begin
            prod_valid <= mac_op.valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (mac_op.valid) begin
            prod_op <= mac_op.opcode;
            // drop the extra fraction bits, keep 32
            prod_q  <= prod_full[FRAC_BITS +: FIX_WIDTH];
        end
    end

    // ========================================
    // stage 2, accumulate
    // ========================================
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            acc_last <= 1'b0;
        end else begin
            acc_last <= prod_valid && (prod_op == OP_LAST);
        end
    end

    always_ff @(posedge aclk) begin
        if (prod_valid) begin
            if (prod_op == OP_LOAD) begin
                acc <= prod_q;
            end else begin
                acc <= acc + prod_q;
            end
        end
    end

    // ========================================
    // output add and clamp
    // ========================================
    always_comb begin
        y_sum    = hist.y_d1 + acc;
        ysat_neg = -ysat;
        if (y_sum > ysat) begin
            y_clamped = ysat;
        end else if (y_sum < ysat_neg) begin
            y_clamped = ysat_neg;
        end else begin
            y_clamped = y_sum;
        end
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            commit <= 1'b0;
            y_out  <= '0;
        end else begin
            commit <= acc_last;
            if (acc_last) begin
                y_out <= y_clamped;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (acc_last) begin
            result <= '{delta_y: acc, y_unsat: y_sum, y_sat: y_clamped};
        end
    end

endmodule

// File: hw/pid_term_sequencer.sv
module pid_term_sequencer (
    input  logic                      aclk,
    input  logic                      rst_n,
    input  logic                      sample_valid,
    input  pid_fixed_pkg::pid_coeff_t coeff,
    input  pid_fixed_pkg::pid_hist_t  hist,
    input  logic                      done,
    output logic                      take,
    output logic                      busy,
    output pid_ctrl_pkg::mac_op_t     mac_op
);
    import pid_fixed_pkg::*;
    import pid_ctrl_pkg::*;

    seq_state_e            state;
    logic [TERM_IDX_W-1:0] term_idx;

    // current term, before the output register
    fix_t                  term_coef;
    fix_t                  term_operand;
    mac_opcode_e           term_opcode;

    // registered op toward the datapath
    logic                  op_valid;
    mac_opcode_e           op_opcode;
    fix_t                  op_coef;
    fix_t                  op_operand;

    assign take = (state == S_IDLE) && sample_valid;
    assign busy = (state != S_IDLE);

    // ========================================
    // term table
    // ========================================
    always_comb begin
        term_coef    = coeff.c7;
        term_operand = hist.aw_err;
        case (term_idx)
            0: begin
                term_coef    = coeff.c1;
                term_operand = hist.cur.w;
            end
            1: begin
                term_coef    = coeff.a0;
                term_operand = hist.dy_d1;
            end
            2: begin
                term_coef    = coeff.c2;
                term_operand = hist.w_d1;
            end
            3: begin
                term_coef    = coeff.c3;
                term_operand = hist.w_d2;
            end
            4: begin
                term_coef    = coeff.c4;
                term_operand = hist.cur.x;
            end
            5: begin
                term_coef    = coeff.c5;
                term_operand = hist.x_d1;
            end
            6: begin
                term_coef    = coeff.c6;
                term_operand = hist.x_d2;
            end
            default: ;
        endcase
    end

    always_comb begin
        if (term_idx == '0) begin
            term_opcode = OP_LOAD;
        end else if (term_idx == TERM_IDX_W'(TERM_COUNT - 1)) begin
            term_opcode = OP_LAST;
        end else begin
            term_opcode = OP_ACC;
        end
    end

    // ========================================
    // FSM
    // ========================================
    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            term_idx <= '0;
            op_valid <= 1'b0;
        end else begin
            op_valid <= (state == S_ISSUE);
            case (state)
                S_IDLE: begin
                    term_idx <= '0;
                    if (sample_valid) begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    term_idx <= term_idx + 1'b1;
                    if (term_idx == TERM_IDX_W'(TERM_COUNT - 1)) begin
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    // wait for the datapath to close the sample
                    if (done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (state == S_ISSUE) begin
            op_opcode  <= term_opcode;
            op_coef    <= term_coef;
            op_operand <= term_operand;
        end
    end

    assign mac_op = '{valid: op_valid, opcode: op_opcode, coef: op_coef, operand: op_operand};

endmodule

// File: project.f
hw/pid_fixed_pkg.sv
hw/pid_ctrl_pkg.sv
hw/pid_term_sequencer.sv
hw/pid_history.sv
hw/pid_mac_datapath.sv
hw/pid_controller.sv
verification/pid_controller_assert.sv
verification/pid_controller_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module pid_controller_tb -f project.f

sim_output=$(./obj_dir/Vpid_controller_tb 2>&1) || true
echo "$sim_output"

if grep -q "All checks passed" <<< "$sim_output"; then
    exit 0
fi
exit 1

// File: verification/pid_controller_assert.sv
module pid_controller_assert (
    input logic                aclk,
    input logic                rst_n,
    input logic                sample_valid,
    input logic                busy,
    input logic                out_valid,
    input pid_fixed_pkg::fix_t y_out,
    input pid_fixed_pkg::fix_t ysat
);
    import pid_fixed_pkg::*;

    logic accept;
    fix_t ysat_neg;

    assign accept   = sample_valid && !busy;
    assign ysat_neg = -ysat;

    out_valid_one_cycle: assert property (@(posedge aclk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else $error("out_valid held longer than one cycle");

    out_valid_while_busy: assert property (@(posedge aclk) disable iff (!rst_n)
        out_valid |-> busy)
        else $error("out_valid without busy");

    // pulse starts at the 11th edge, so it is sampled high at the 12th
    out_valid_latency: assert property (@(posedge aclk) disable iff (!rst_n)
        accept |-> ##11 !out_valid ##1 out_valid)
        else $error("out_valid not 11 cycles after acceptance");

    y_out_in_range: assert property (@(posedge aclk) disable iff (!rst_n)
        out_valid |-> (y_out <= ysat) && (y_out >= ysat_neg))
        else $error("y_out outside the saturation band");

endmodule

bind pid_controller pid_controller_assert pid_controller_assert_i (
    .aclk         (aclk),
    .rst_n        (rst_n),
    .sample_valid (sample_valid),
    .busy         (busy),
    .out_valid    (out_valid),
    .y_out        (y_out),
    .ysat         (ysat)
);

// File: verification/pid_controller_tb.sv
module pid_controller_tb;
    import pid_fixed_pkg::*;

    typedef struct {
        pid_sample_t sample;
        pid_coeff_t  coeff;
        fix_t        ysat;
        bit          early;
        fix_t        y_exp;
    } row_t;

    logic        aclk;
    logic        rst_n;
    logic        sample_valid;
    pid_sample_t sample;
    pid_coeff_t  coeff;
    fix_t        ysat;
    fix_t        y_out;
    logic        busy;
    logic        out_valid;

    row_t        rows[$];
    bit          table_ready = 1'b0;
    int          pulse_count = 0;
    logic [31:0] lfsr = 32'h89c6;

    pid_controller pid_controller_i (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .sample       (sample),
        .coeff        (coeff),
        .ysat         (ysat),
        .y_out        (y_out),
        .busy         (busy),
        .out_valid    (out_valid)
    );

    always #20 aclk = ~aclk;

    always @(negedge aclk) begin
        if (out_valid) begin
            pulse_count <= pulse_count + 1;
        end
    end

    // ========================================
    // helpers
    // ========================================
    function automatic fix_t to_fix(input int v);
        return v <<< FRAC_BITS;
    endfunction

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    // idle gap of 0..7 cycles, one step per bit
    task automatic draw_gap(output int gap);
        gap = 0;
        repeat (3) begin
            gap = (gap << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Fail %s: actual 0x%h, expected 0x%h", name, actual, expected);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    function automatic void add_row(input int w, input int x, input int a0, input int c1,
                                    input int c2, input int c3, input int c4, input int c5,
                                    input int c6, input int c7, input int ysat_v,
                                    input int early, input int y_exp);
        row_t r;
        r.sample = '{w: to_fix(w), x: to_fix(x)};
        r.coeff  = '{a0: to_fix(a0), c1: to_fix(c1), c2: to_fix(c2), c3: to_fix(c3),
                     c4: to_fix(c4), c5: to_fix(c5), c6: to_fix(c6), c7: to_fix(c7)};
        r.ysat   = to_fix(ysat_v);
        r.early  = (early != 0);
        r.y_exp  = to_fix(y_exp);
        rows.push_back(r);
    endfunction

    // ========================================
    // stimulus table
    // ========================================
    // rows run in order, history carries over
    function automatic void fill_table();
        //        w    x  a0  c1  c2  c3  c4  c5  c6  c7 ysat  e    y
        add_row(  3,   0,  0,  2,  0,  0,  0,  0,  0,  0, 100, 0,   6);
        add_row(  3,   0,  0,  2,  0,  0,  0,  0,  0,  0, 100, 1,  12);
        add_row(  5,   7,  0,  0,  1,  0,  0,  0,  0,  0, 100, 0,  15);
        add_row( -4,   2,  0,  0,  0,  2,  0,  0,  0,  0, 100, 0,  21);
        add_row(  1,   9,  0,  0,  0,  0,  0,  3,  0,  0, 100, 1,  27);
        add_row(  0,  -3,  0,  0,  0,  0,  0,  0, -2,  0, 100, 0,  23);
        add_row(  6,   4,  5,  0,  0,  0,  0,  0,  0,  0, 100, 0,   3);
        add_row(  2,  -5,  0,  0,  1,  0,  3,  0,  0,  0, 100, 0,  -6);
        // saturation high, then back-calculation pulls y inside
        add_row( 50,   0,  0,  2,  0,  0,  0,  0,  0,  0,  20, 0,  20);
        add_row( -5,   0,  0,  1,  0,  0,  0,  0,  0,  1,  20, 1,  15);
        add_row(-40,   0,  0,  2,  0,  0,  0,  0,  0,  0,  20, 0, -20);
        add_row( 10,   0,  0,  1,  0,  0,  0,  0,  0,  1,  20, 0, -10);
        add_row(  4,   3,  0,  1,  1,  1, -1,  2,  2,  3,  50, 0, -39);
    endfunction

    // drives on the falling edge, samples outputs there too
    task automatic apply_row(input row_t r, input fix_t prev_y, input int count);
        int edges;
        check_value("busy", 32'(busy), 32'd0);
        check_value("y_out", y_out, prev_y);
        sample       = r.sample;
        coeff        = r.coeff;
        ysat         = r.ysat;
        sample_valid = 1'b1;
        @(negedge aclk);
        sample_valid = 1'b0;
        check_value("busy", 32'(busy), 32'd1);
        // rising edges seen since the accepting edge
        edges = 0;
        while (!out_valid) begin
            // stray strobe with other data while busy
            if (r.early && edges == 3) begin
                sample_valid = 1'b1;
                sample.w     = to_fix(77);
            end else begin
                sample_valid = 1'b0;
                sample       = r.sample;
            end
            @(negedge aclk);
            edges++;
        end
        check_value("out_valid latency", 32'(edges), 32'd11);
        check_value("y_out", y_out, r.y_exp);
        @(negedge aclk);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_value("out_valid count", 32'(pulse_count), 32'(count));
    endtask

    // ========================================
    // main sequence
    // ========================================
    initial begin : stimulus
        int   gap;
        fix_t prev_y;
        aclk         = 1'b0;
        rst_n        = 1'b0;
        sample_valid = 1'b0;
        sample       = '0;
        coeff        = '0;
        ysat         = '0;
        prev_y       = '0;
        fill_table();
        table_ready = 1'b1;
        repeat (16) @(negedge aclk);
        check_value("busy", 32'(busy), 32'd0);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("y_out", y_out, 32'd0);
        rst_n = 1'b1;
        @(negedge aclk);
        foreach (rows[i]) begin
            draw_gap(gap);
            repeat (gap) @(negedge aclk);
            apply_row(rows[i], prev_y, i + 1);
            prev_y = rows[i].y_exp;
        end
        $display("All checks passed");
        $finish;
    end

    initial begin : watchdog
        longint limit;
        wait (table_ready);
        limit = (longint'(rows.size()) * (12 + 8) + 100) * 40;
        #(limit);
        $display("simulation timed out before all samples were processed");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule
